//--- Makefile
# Verilator build and run for the barcode core

VERILATOR  ?= verilator
TOP        := tb_barcode_core
FILELIST   := barcode_core.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing -j 0 --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing
LOG        := sim.log
FAIL_MSG   := TEST FAILED
PASS_MSG   := TEST PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation ended without result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- barcode_core.f
src/barcode_pkg.sv
src/frame_capture.sv
src/bit_plane_ram.sv
src/label_match.sv
src/scan_ctrl.sv
src/barcode_core.sv
testbench/tb_barcode_core.sv

//--- src/barcode_core.sv
`timescale 1ns/1ps

module barcode_core import barcode_pkg::*; #(
	parameter int IMG_W = IMG_W_DEF,
	parameter int IMG_H = IMG_H_DEF
) (
	input  logic        i_clk,
	input  logic        i_rst_n,
	input  logic        i_in_valid,
	input  logic [31:0] i_in_data,	// four pixels, leftmost in the top byte
	output logic        o_in_ready,
	output logic        o_result_valid,
	output logic        o_found,
	output logic [7:0]  o_kernel,
	output logic [7:0]  o_stride,
	output logic [7:0]  o_dilation
);

	localparam int ROW_W = $clog2(IMG_H);
	localparam int COL_W = $clog2(IMG_W);

	logic             start_w;	// controller to capture
	logic             frame_done_w;
	logic             wr_en_w;
	logic [ROW_W-1:0] wr_row_w;
	logic [IMG_W-1:0] wr_data_w;
	logic [ROW_W-1:0] rd_row_a_w, rd_row_b_w;	// row pair under test
	logic [IMG_W-1:0] rd_data_a_w, rd_data_b_w;
	logic [COL_W-1:0] col_w;
	logic             match_w;
	sym_e             sym_kernel_w, sym_stride_w, sym_dilation_w;

	frame_capture #(.IMG_W(IMG_W), .IMG_H(IMG_H)) u_capture (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_start(start_w),
		.i_in_valid(i_in_valid), .i_in_data(i_in_data), .o_in_ready(o_in_ready),
		.o_frame_done(frame_done_w), .o_wr_en(wr_en_w), .o_wr_row(wr_row_w),
		.o_wr_data(wr_data_w)
	);

	bit_plane_ram #(.IMG_W(IMG_W), .IMG_H(IMG_H)) u_plane (
		.i_clk(i_clk), .i_wr_en(wr_en_w), .i_wr_row(wr_row_w), .i_wr_data(wr_data_w),
		.i_rd_row_a(rd_row_a_w), .i_rd_row_b(rd_row_b_w),
		.o_rd_data_a(rd_data_a_w), .o_rd_data_b(rd_data_b_w)
	);

	label_match #(.IMG_W(IMG_W), .IMG_H(IMG_H)) u_match (
		.i_row_top(rd_data_a_w), .i_row_bot(rd_data_b_w), .i_col(col_w),
		.o_match(match_w), .o_sym_kernel(sym_kernel_w), .o_sym_stride(sym_stride_w),
		.o_sym_dilation(sym_dilation_w)
	);

	scan_ctrl #(.IMG_W(IMG_W), .IMG_H(IMG_H)) u_ctrl (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_frame_done(frame_done_w),
		.i_match(match_w), .i_sym_kernel(sym_kernel_w), .i_sym_stride(sym_stride_w),
		.i_sym_dilation(sym_dilation_w), .o_start(start_w),
		.o_rd_row_a(rd_row_a_w), .o_rd_row_b(rd_row_b_w), .o_col(col_w),
		.o_result_valid(o_result_valid), .o_found(o_found), .o_kernel(o_kernel),
		.o_stride(o_stride), .o_dilation(o_dilation)
	);

endmodule

//--- src/barcode_pkg.sv
package barcode_pkg;

	// image geometry
	localparam int IMG_W_DEF    = 64;	// pixels per row
	localparam int IMG_H_DEF    = 64;	// rows per frame
	localparam int PIX_PER_BEAT = 4;	// pixels in one 32-bit input word

	// label layout in modules
	localparam int SYM_LEN        = 11;	// start code and each data symbol
	localparam int STOP_LEN       = 13;	// stop code is two modules longer
	localparam int LABEL_LEN      = 4 * SYM_LEN + STOP_LEN;	// start + 3 symbols + stop = 57
	localparam int LABEL_ROW_SPAN = 9;	// lower copy of start/stop sits this many rows down

	// offsets of the fields inside one label window
	localparam int OFS_KERNEL   = SYM_LEN;
	localparam int OFS_STRIDE   = 2 * SYM_LEN;
	localparam int OFS_DILATION = 3 * SYM_LEN;
	localparam int OFS_STOP     = 4 * SYM_LEN;

	// module patterns stored in pixel order
	// bit 0 is the leftmost module, so these read mirrored against the printed code
	localparam logic [SYM_LEN-1:0]  PAT_START = 11'b001_1100_1011;	// printed 11010011100
	localparam logic [STOP_LEN-1:0] PAT_STOP  = 13'b1_1010_1110_0011;	// printed 1100011101011
	localparam logic [SYM_LEN-1:0]  PAT_C1    = 11'b001_1011_0011;	// printed 11001101100
	localparam logic [SYM_LEN-1:0]  PAT_C2    = 11'b011_0011_0011;	// printed 11001100110
	localparam logic [SYM_LEN-1:0]  PAT_C3    = 11'b000_1100_1001;	// printed 10010011000

	// classified data symbol
	typedef enum logic [1:0] {
		SYM_NONE = 2'd0,	// no known pattern
		SYM_1    = 2'd1,
		SYM_2    = 2'd2,
		SYM_3    = 2'd3
	} sym_e;

	// frame level controller
	typedef enum logic [1:0] {
		ST_IDLE    = 2'd0,	// one cycle, kicks off capture
		ST_CAPTURE = 2'd1,	// waiting for the last beat
		ST_SCAN    = 2'd2,	// one candidate per cycle
		ST_REPORT  = 2'd3	// result valid for one cycle
	} ctrl_state_e;

endpackage

//--- src/bit_plane_ram.sv
`timescale 1ns/1ps

module bit_plane_ram #(
	parameter int IMG_W = 64,
	parameter int IMG_H = 64
) (
	input  logic                     i_clk,
	input  logic                     i_wr_en,
	input  logic [$clog2(IMG_H)-1:0] i_wr_row,
	input  logic [IMG_W-1:0]         i_wr_data,
	input  logic [$clog2(IMG_H)-1:0] i_rd_row_a,	// upper check row
	input  logic [$clog2(IMG_H)-1:0] i_rd_row_b,	// lower check row
	output logic [IMG_W-1:0]         o_rd_data_a,
	output logic [IMG_W-1:0]         o_rd_data_b
);

	// one word per image row, bit c is column c
	logic [IMG_W-1:0] mem_r [IMG_H];

	// whole row per write
	always_ff @(posedge i_clk) begin
		if (i_wr_en) begin
			mem_r[i_wr_row] <= i_wr_data;
		end
	end

	// both ports read combinationally
	// matcher sees the rows in the same cycle as the address
	assign o_rd_data_a = mem_r[i_rd_row_a];
	assign o_rd_data_b = mem_r[i_rd_row_b];

endmodule

//--- src/frame_capture.sv
`timescale 1ns/1ps

module frame_capture import barcode_pkg::*; #(
	parameter int IMG_W = 64,
	parameter int IMG_H = 64
) (
	input  logic                     i_clk,
	input  logic                     i_rst_n,
	input  logic                     i_start,	// one-cycle pulse from the controller
	input  logic                     i_in_valid,
	input  logic [31:0]              i_in_data,
	output logic                     o_in_ready,
	output logic                     o_frame_done,	// pulse after the last beat
	output logic                     o_wr_en,
	output logic [$clog2(IMG_H)-1:0] o_wr_row,
	output logic [IMG_W-1:0]         o_wr_data
);

	localparam int BEATS_PER_ROW = IMG_W / PIX_PER_BEAT;
	localparam int BEAT_W        = $clog2(BEATS_PER_ROW);
	localparam int ROW_W         = $clog2(IMG_H);

	logic [BEAT_W-1:0]       beat_cnt_r;	// beat within the current row
	logic [ROW_W-1:0]        row_cnt_r;	// row being assembled
	logic [IMG_W-1:0]        row_sr_r;	// partial row, fills from the top
	logic [PIX_PER_BEAT-1:0] beat_bits_w;	// pixel lsbs of this beat, leftmost at bit 0
	logic                    accept_w;
	logic                    row_last_w;
	logic                    frame_last_w;

	assign accept_w     = i_in_valid & o_in_ready;
	assign row_last_w   = (beat_cnt_r == BEAT_W'(BEATS_PER_ROW - 1));
	assign frame_last_w = row_last_w & (row_cnt_r == ROW_W'(IMG_H - 1));

	// leftmost pixel lives in the top byte of the word
	always_comb begin
		for (int p = 0; p < PIX_PER_BEAT; p++) begin
			beat_bits_w[p] = i_in_data[(PIX_PER_BEAT - 1 - p) * 8];	// lsb of pixel p
		end
	end

	// shift right by one beat, new pixels enter at the high end
	// after a full row the first beat has reached column 0
	assign o_wr_data = {beat_bits_w, row_sr_r[IMG_W-1:PIX_PER_BEAT]};
	assign o_wr_en   = accept_w & row_last_w;	// row written on its own last beat
	assign o_wr_row  = row_cnt_r;

	always_ff @(posedge i_clk) begin
		if (accept_w) begin
			row_sr_r <= o_wr_data;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_in_ready   <= 1'b0;
			o_frame_done <= 1'b0;
			beat_cnt_r   <= '0;
			row_cnt_r    <= '0;
		end else begin
			o_frame_done <= accept_w & frame_last_w;
			if (i_start) begin
				o_in_ready <= 1'b1;	// ready the cycle after start
			end else if (accept_w && frame_last_w) begin
				o_in_ready <= 1'b0;	// whole frame taken
			end
			if (accept_w) begin
				if (row_last_w) begin
					beat_cnt_r <= '0;
					row_cnt_r  <= frame_last_w ? '0 : row_cnt_r + 1'b1;	// wraps for next frame
				end else begin
					beat_cnt_r <= beat_cnt_r + 1'b1;
				end
			end
		end
	end

endmodule

//--- src/label_match.sv
`timescale 1ns/1ps

module label_match import barcode_pkg::*; #(
	parameter int IMG_W = 64,
	parameter int IMG_H = 64
) (
	input  logic [IMG_W-1:0]         i_row_top,
	input  logic [IMG_W-1:0]         i_row_bot,	// LABEL_ROW_SPAN rows below i_row_top
	input  logic [$clog2(IMG_W)-1:0] i_col,	// leftmost column of the candidate
	output logic                     o_match,
	output sym_e                     o_sym_kernel,
	output sym_e                     o_sym_stride,
	output sym_e                     o_sym_dilation
);

	logic [LABEL_LEN-1:0] win_top_w;	// candidate window, upper row
	logic [LABEL_LEN-1:0] win_bot_w;	// candidate window, lower row
	logic                 top_ok_w;
	logic                 bot_ok_w;

	// 11-bit symbol to its class
	function automatic sym_e classify(input logic [SYM_LEN-1:0] s);
		sym_e res;
		case (s)
			PAT_C1:  res = SYM_1;
			PAT_C2:  res = SYM_2;
			PAT_C3:  res = SYM_3;
			default: res = SYM_NONE;
		endcase
		return res;
	endfunction

	// start/stop framing of one window
	function automatic logic framed(input logic [LABEL_LEN-1:0] w);
		return (w[SYM_LEN-1:0] == PAT_START) && (w[OFS_STOP +: STOP_LEN] == PAT_STOP);
	endfunction

	// shift puts column i_col at bit 0 and the cast keeps one label width
	assign win_top_w = LABEL_LEN'(i_row_top >> i_col);
	assign win_bot_w = LABEL_LEN'(i_row_bot >> i_col);

	assign top_ok_w = framed(win_top_w);
	assign bot_ok_w = framed(win_bot_w);	// lower copy carries start/stop only
	assign o_match  = top_ok_w & bot_ok_w;

	// data symbols come from the upper row only
	assign o_sym_kernel   = classify(win_top_w[OFS_KERNEL +: SYM_LEN]);
	assign o_sym_stride   = classify(win_top_w[OFS_STRIDE +: SYM_LEN]);
	assign o_sym_dilation = classify(win_top_w[OFS_DILATION +: SYM_LEN]);

endmodule

//--- src/scan_ctrl.sv
`timescale 1ns/1ps

module scan_ctrl import barcode_pkg::*; #(
	parameter int IMG_W = 64,
	parameter int IMG_H = 64
) (
	input  logic                     i_clk,
	input  logic                     i_rst_n,
	input  logic                     i_frame_done,
	input  logic                     i_match,
	input  sym_e                     i_sym_kernel,
	input  sym_e                     i_sym_stride,
	input  sym_e                     i_sym_dilation,
	output logic                     o_start,
	output logic [$clog2(IMG_H)-1:0] o_rd_row_a,
	output logic [$clog2(IMG_H)-1:0] o_rd_row_b,
	output logic [$clog2(IMG_W)-1:0] o_col,
	output logic                     o_result_valid,
	output logic                     o_found,
	output logic [7:0]               o_kernel,
	output logic [7:0]               o_stride,
	output logic [7:0]               o_dilation
);

	localparam int ROW_W = $clog2(IMG_H);
	localparam int COL_W = $clog2(IMG_W);
	localparam logic [ROW_W-1:0] ROW_LAST = ROW_W'(IMG_H - LABEL_ROW_SPAN - 1);
	localparam logic [COL_W-1:0] COL_LAST = COL_W'(IMG_W - LABEL_LEN);

	ctrl_state_e      state_r;
	ctrl_state_e      state_nxt_w;
	logic [ROW_W-1:0] row_r;	// upper row of the candidate
	logic [COL_W-1:0] col_r;
	logic             col_end_w;
	logic             scan_end_w;	// last candidate this cycle
	logic             seen_r;	// some candidate matched in this scan
	sym_e             kern_r, strd_r, dil_r;	// symbols of latest match
	sym_e             kern_w, strd_w, dil_w;	// same, counting the current candidate
	logic             hit_w;
	logic [7:0]       kern_val_w, strd_val_w, dil_val_w;
	logic             ok_w;

	function automatic logic [7:0] sym_value(input sym_e s);
		logic [7:0] v;
		case (s)
			SYM_1:   v = 8'd1;
			SYM_2:   v = 8'd2;
			SYM_3:   v = 8'd3;
			default: v = 8'd0;
		endcase
		return v;
	endfunction

	assign col_end_w  = (col_r == COL_LAST);
	assign scan_end_w = (state_r == ST_SCAN) & col_end_w & (row_r == ROW_LAST);

	always_comb begin
		state_nxt_w = state_r;
		case (state_r)
			ST_IDLE:    state_nxt_w = ST_CAPTURE;
			ST_CAPTURE: if (i_frame_done) state_nxt_w = ST_SCAN;
			ST_SCAN:    if (scan_end_w) state_nxt_w = ST_REPORT;
			ST_REPORT:  state_nxt_w = ST_IDLE;	// back for the next frame
			default:    state_nxt_w = ST_IDLE;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_r <= ST_IDLE;
			row_r   <= '0;
			col_r   <= '0;
			seen_r  <= 1'b0;
		end else begin
			state_r <= state_nxt_w;
			if (state_r == ST_SCAN) begin
				if (col_end_w) begin
					col_r <= '0;
					row_r <= scan_end_w ? '0 : row_r + 1'b1;	// counters idle at 0
				end else begin
					col_r <= col_r + 1'b1;
				end
				if (i_match) seen_r <= 1'b1;
			end else if (state_r == ST_IDLE) begin
				seen_r <= 1'b0;	// fresh frame
			end
		end
	end

	// later match in scan order overwrites
	always_ff @(posedge i_clk) begin
		if (state_r == ST_SCAN && i_match) begin
			kern_r <= i_sym_kernel;
			strd_r <= i_sym_stride;
			dil_r  <= i_sym_dilation;
		end
	end

	// final candidate is still combinational when the scan ends
	assign hit_w  = i_match | seen_r;
	assign kern_w = i_match ? i_sym_kernel : kern_r;
	assign strd_w = i_match ? i_sym_stride : strd_r;
	assign dil_w  = i_match ? i_sym_dilation : dil_r;

	assign kern_val_w = sym_value(kern_w);
	assign strd_val_w = sym_value(strd_w);
	assign dil_val_w  = sym_value(dil_w);

	// kernel only 3, stride and dilation 1 or 2
	assign ok_w = hit_w && (kern_val_w == 8'd3) &&
		(strd_val_w == 8'd1 || strd_val_w == 8'd2) &&
		(dil_val_w == 8'd1 || dil_val_w == 8'd2);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_found    <= 1'b0;
			o_kernel   <= 8'd0;
			o_stride   <= 8'd0;
			o_dilation <= 8'd0;
		end else if (scan_end_w) begin
			o_found    <= ok_w;
			o_kernel   <= ok_w ? kern_val_w : 8'd0;	// zeros unless the whole label is legal
			o_stride   <= ok_w ? strd_val_w : 8'd0;
			o_dilation <= ok_w ? dil_val_w : 8'd0;
		end
	end

	assign o_start        = (state_r == ST_IDLE);
	assign o_result_valid = (state_r == ST_REPORT);
	assign o_rd_row_a     = row_r;
	assign o_rd_row_b     = row_r + ROW_W'(LABEL_ROW_SPAN);
	assign o_col          = col_r;

endmodule

//--- testbench/tb_barcode_core.sv
`timescale 1ns/1ps

module tb_barcode_core import barcode_pkg::*; ();

	localparam int IMG_W      = IMG_W_DEF;
	localparam int IMG_H      = IMG_H_DEF;
	localparam int NPIX       = IMG_W * IMG_H;
	localparam int NBEATS     = NPIX / PIX_PER_BEAT;
	localparam int MAX_GAP    = 3;	// longest idle stretch before one beat
	localparam int SCAN_CYC   = (IMG_H - LABEL_ROW_SPAN) * (IMG_W - LABEL_LEN + 1);
	localparam int FRAME_CYC  = NBEATS * (MAX_GAP + 1) + SCAN_CYC + 16;	// worst case per frame
	localparam int N_FRAMES   = 9;	// frames sent over all tests
	localparam int MAX_CYCLES = 10 + N_FRAMES * FRAME_CYC + 100;

	logic        i_clk;
	logic        i_rst_n;
	logic        i_in_valid;
	logic [31:0] i_in_data;
	logic        o_in_ready;
	logic        o_result_valid;
	logic        o_found;
	logic [7:0]  o_kernel;
	logic [7:0]  o_stride;
	logic [7:0]  o_dilation;

	logic [7:0]  img [NPIX];	// raster order, pixel lsb is the bit plane
	logic [31:0] lcg_state;
	int          cycle_cnt = 0;
	int          n_checks = 0;
	int          n_errors = 0;
	int          n_tests = 0;
	int          n_failed = 0;

	barcode_core #(.IMG_W(IMG_W), .IMG_H(IMG_H)) i_dut (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_in_valid(i_in_valid), .i_in_data(i_in_data),
		.o_in_ready(o_in_ready), .o_result_valid(o_result_valid), .o_found(o_found),
		.o_kernel(o_kernel), .o_stride(o_stride), .o_dilation(o_dilation)
	);

	initial i_clk = 1'b0;
	always #20 i_clk = ~i_clk;	// 40 ns period

	// watchdog over the whole run
	always @(posedge i_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("timeout: no result seen after %0d cycles", cycle_cnt);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// symbol number 1..3 to its module pattern
	function automatic logic [SYM_LEN-1:0] pat_for(input int n);
		logic [SYM_LEN-1:0] p;
		case (n)
			1:       p = PAT_C1;
			2:       p = PAT_C2;
			default: p = PAT_C3;
		endcase
		return p;
	endfunction

	task automatic fill_image();
		logic [31:0] r;
		for (int i = 0; i < NPIX; i++) begin
			r = lcg_next();
			img[i] = {r[30:24], 1'b0};	// noise above the lsb, plane starts empty
		end
	endtask

	// label modules go left to right from col, bit 0 of each pattern first
	task automatic place_label(input int row, input int col, input int kern, input int strd,
		input int dil, input logic with_lower);
		logic [LABEL_LEN-1:0] lbl;
		lbl = {PAT_STOP, pat_for(dil), pat_for(strd), pat_for(kern), PAT_START};
		for (int i = 0; i < LABEL_LEN; i++) begin
			img[row * IMG_W + col + i][0] = lbl[i];
			if (with_lower) begin
				img[(row + LABEL_ROW_SPAN) * IMG_W + col + i][0] = lbl[i];	// second copy
			end
		end
	endtask

	// called on a rising edge, returns on the edge that took the last beat
	task automatic send_frame(input logic gaps);
		logic [31:0] r;
		int          idle;
		for (int b = 0; b < NBEATS; b++) begin
			idle = 0;
			if (gaps) begin
				r = lcg_next();
				if (r[9:8] == 2'b00) idle = int'(r[5:4]);	// roughly one beat in four waits
			end
			if (idle > 0) begin
				i_in_valid <= 1'b0;
				repeat (idle) @(posedge i_clk);
			end
			i_in_valid <= 1'b1;
			i_in_data  <= {img[4 * b], img[4 * b + 1], img[4 * b + 2], img[4 * b + 3]};
			@(negedge i_clk);
			while (!o_in_ready) @(negedge i_clk);	// transfer on the coming edge
			@(posedge i_clk);
		end
		i_in_valid <= 1'b0;
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		n_checks++;
		if (act !== exp) begin
			$display("mismatch at %0t: %s expected %0b got %0b", $time, name, exp, act);
			n_errors++;
		end
	endtask

	task automatic check_param(input string name, input logic [7:0] exp, input logic [7:0] act);
		n_checks++;
		if (act !== exp) begin
			$display("mismatch at %0t: %s expected %0d got %0d", $time, name, exp, act);
			n_errors++;
		end
	endtask

	// waits for the report cycle and compares all result outputs
	task automatic expect_result(input logic found, input int kern, input int strd, input int dil);
		@(negedge i_clk);
		while (!o_result_valid) @(negedge i_clk);
		check_flag("o_found", found, o_found);
		check_param("o_kernel", 8'(kern), o_kernel);
		check_param("o_stride", 8'(strd), o_stride);
		check_param("o_dilation", 8'(dil), o_dilation);
		@(negedge i_clk);
		check_flag("o_result_valid", 1'b0, o_result_valid);	// report lasts one cycle
		@(posedge i_clk);
	endtask

	task automatic report_test(input string name, input int err_before);
		n_tests++;
		if (n_errors == err_before) begin
			$display("%s: pass", name);
		end else begin
			n_failed++;
			$display("%s: fail, %0d mismatches", name, n_errors - err_before);
		end
	endtask

	task automatic test_basic_label();
		int e0;
		e0 = n_errors;
		fill_image();
		place_label(5, 0, 3, 1, 1, 1'b1);
		send_frame(1'b0);
		expect_result(1'b1, 3, 1, 1);
		report_test("basic_label", e0);
	endtask

	task automatic test_scan_bounds();
		int e0;
		e0 = n_errors;
		fill_image();
		place_label(IMG_H - LABEL_ROW_SPAN - 1, IMG_W - LABEL_LEN, 3, 2, 2, 1'b1);	// last pair, last col
		send_frame(1'b0);
		expect_result(1'b1, 3, 2, 2);
		report_test("scan_bounds", e0);
	endtask

	task automatic test_no_label();
		int e0;
		e0 = n_errors;
		fill_image();
		send_frame(1'b0);
		@(negedge i_clk);
		check_flag("o_in_ready", 1'b0, o_in_ready);	// frame complete, no more beats taken
		expect_result(1'b0, 0, 0, 0);
		report_test("no_label", e0);
	endtask

	task automatic test_invalid_label();
		int e0;
		e0 = n_errors;
		fill_image();
		place_label(20, 3, 1, 2, 1, 1'b1);	// kernel symbol is not 3
		send_frame(1'b0);
		expect_result(1'b0, 0, 0, 0);
		fill_image();
		place_label(12, 4, 3, 1, 1, 1'b0);	// legal symbols but lower copy missing
		send_frame(1'b0);
		expect_result(1'b0, 0, 0, 0);
		report_test("invalid_label", e0);
	endtask

	task automatic test_last_match_wins();
		int e0;
		e0 = n_errors;
		fill_image();
		place_label(8, 2, 3, 1, 2, 1'b1);
		place_label(30, 6, 3, 2, 1, 1'b1);	// later in scan order
		send_frame(1'b0);
		expect_result(1'b1, 3, 2, 1);
		report_test("last_match_wins", e0);
	endtask

	task automatic test_back_to_back();
		int          e0;
		int          kern, strd, dil, row, col;
		logic        legal;
		logic [31:0] r;
		e0 = n_errors;
		for (int f = 0; f < 3; f++) begin
			fill_image();
			r    = lcg_next();
			kern = (f == 0) ? 3 : int'(r % 32'd3) + 1;	// first frame always legal kernel
			strd = int'((r >> 8) % 32'd3) + 1;
			dil  = int'((r >> 16) % 32'd3) + 1;
			r    = lcg_next();
			row  = int'(r % 32'(IMG_H - LABEL_ROW_SPAN));
			col  = int'((r >> 16) % 32'(IMG_W - LABEL_LEN + 1));
			place_label(row, col, kern, strd, dil, 1'b1);
			legal = (kern == 3) && (strd <= 2) && (dil <= 2);
			send_frame(1'b1);
			if (legal) expect_result(1'b1, kern, strd, dil);
			else expect_result(1'b0, 0, 0, 0);
		end
		report_test("back_to_back", e0);
	endtask

	initial begin
		lcg_state  = 32'h2567_e534;
		i_rst_n    = 1'b0;
		i_in_valid = 1'b0;
		i_in_data  = 32'd0;
		repeat (10) @(posedge i_clk);
		i_rst_n <= 1'b1;
		@(posedge i_clk);
		test_basic_label();
		test_scan_bounds();
		test_no_label();
		test_invalid_label();
		test_last_match_wins();
		test_back_to_back();
		$display("tests %0d, failed %0d, checks %0d, mismatches %0d",
			n_tests, n_failed, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
